//--- common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// integer register width, RV64
`define XLEN 64

// fixed instruction width, no compressed forms
`define ILEN 32

// one quotient or product bit per iteration
`define MULDIV_ITERS 64

`endif

//--- common/riscvPkg.sv
`include "core_config.svh"

package riscvPkg;

    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        SYSTEM    = 7'b1110011
    } opcode_t;

    // same word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            opcode_t    opcode;
        } sFmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            opcode_t    opcode;
        } bFmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            opcode_t     opcode;
        } uFmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            opcode_t    opcode;
        } jFmt;
    } instrWord_t;

    typedef enum logic [2:0] {ADD, SUB, XOR, OR, AND, SLL, SRL, SRA} aluOp_t;

    // values follow funct3 of the M extension
    typedef enum logic [2:0] {
        MUL  = 3'b000,
        DIV  = 3'b100,
        DIVU = 3'b101,
        REM  = 3'b110,
        REMU = 3'b111
    } mulDivOp_t;

    typedef enum logic [1:0] {SIGNED_LT, UNSIGNED_LT, EQUAL} flagSel_t;
    typedef enum logic [1:0] {ZERO, RS1, PC} srcASel_t;
    typedef enum logic [1:0] {RS2, IMM, FOUR} srcBSel_t;

    typedef struct packed {
        aluOp_t     aluOp;
        mulDivOp_t  mulDivOp;
        logic       isMulDiv;
        logic       isWord;      // 32-bit op, result sign-extended
        srcASel_t   srcA;
        srcBSel_t   srcB;
        logic       isBranch;
        logic       isJump;
        logic       isCompare;   // slt family, value is the flag
        flagSel_t   useFlag;
        logic       flagInv;
        logic       writeBack;
        logic       illegal;
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic [`XLEN-1:0] value;
        logic [4:0]       rd;
        logic             branchTaken;
        logic             illegal;
    } execResult_t;

endpackage

//--- compile.f
+incdir+common
common/riscvPkg.sv
decode/mainDecoder.sv
decode/immGen.sv
verilog/alu.sv
muldiv/mulDivCtrl.sv
muldiv/iterCounter.sv
muldiv/mulDivDatapath.sv
verilog/execStage.sv
testbench/execStage_tb.sv

//--- decode/immGen.sv
`timescale 1ns/100ps
`include "core_config.svh"

module immGen (
    input  riscvPkg::instrWord_t instr,
    output logic [`XLEN-1:0]     imm
);
    always_comb begin
        case (instr.rFmt.opcode)
            riscvPkg::OP_IMM, riscvPkg::OP_IMM_32, riscvPkg::LOAD, riscvPkg::JALR:
                imm = {{(`XLEN-12){instr.iFmt.imm[11]}}, instr.iFmt.imm};
            riscvPkg::STORE:
                imm = {{(`XLEN-12){instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            riscvPkg::BRANCH:
                imm = {{(`XLEN-12){instr.bFmt.imm12}}, instr.bFmt.imm11,
                       instr.bFmt.imm10to5, instr.bFmt.imm4to1, 1'b0};
            riscvPkg::LUI, riscvPkg::AUIPC:
                imm = {{(`XLEN-32){instr.uFmt.imm[19]}}, instr.uFmt.imm, 12'b0}; // pre-shifted
            riscvPkg::JAL:
                imm = {{(`XLEN-20){instr.jFmt.imm20}}, instr.jFmt.imm19to12,
                       instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
            riscvPkg::SYSTEM:
                imm = {{(`XLEN-12){1'b0}}, instr.iFmt.imm}; // csr address, zero-extended
            default:
                imm = '0;
        endcase
    end

endmodule

//--- decode/mainDecoder.sv
`timescale 1ns/100ps

module mainDecoder (
    input  riscvPkg::instrWord_t instr,
    output riscvPkg::ctrl_t      ctrl
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       badWordFunct;

    assign funct3       = instr.rFmt.funct3;
    assign funct7       = instr.rFmt.funct7;
    assign badWordFunct = !(funct3 inside {3'b000, 3'b001, 3'b101}); // only add/sll/srl in W

    function automatic riscvPkg::aluOp_t aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  aluFromFunct3 = alt ? riscvPkg::SUB : riscvPkg::ADD;
            3'b001:  aluFromFunct3 = riscvPkg::SLL;
            3'b100:  aluFromFunct3 = riscvPkg::XOR;
            3'b101:  aluFromFunct3 = alt ? riscvPkg::SRA : riscvPkg::SRL;
            3'b110:  aluFromFunct3 = riscvPkg::OR;
            3'b111:  aluFromFunct3 = riscvPkg::AND;
            default: aluFromFunct3 = riscvPkg::SUB; // slt/sltu, value comes from flags
        endcase
    endfunction

    always_comb begin
        ctrl           = '0;
        ctrl.srcA      = riscvPkg::RS1;
        ctrl.srcB      = riscvPkg::IMM;
        ctrl.writeBack = 1'b1;
        ctrl.rd        = instr.rFmt.rd;
        case (instr.rFmt.opcode)
            riscvPkg::OP, riscvPkg::OP_32: begin
                ctrl.srcB   = riscvPkg::RS2;
                ctrl.isWord = (instr.rFmt.opcode == riscvPkg::OP_32);
                if (funct7 == 7'b0000001) begin // M extension
                    ctrl.isMulDiv = 1'b1;
                    ctrl.mulDivOp = riscvPkg::mulDivOp_t'(funct3);
                    ctrl.illegal  = funct3 inside {3'b001, 3'b010, 3'b011}; // no mulh*
                end else begin
                    ctrl.aluOp     = aluFromFunct3(funct3, funct7[5]);
                    ctrl.isCompare = !ctrl.isWord && (funct3[2:1] == 2'b01);
                    ctrl.useFlag   = funct3[0] ? riscvPkg::UNSIGNED_LT : riscvPkg::SIGNED_LT;
                    ctrl.illegal   = (funct7 != 7'b0000000 && funct7 != 7'b0100000)
                                   || (funct7[5] && funct3 != 3'b000 && funct3 != 3'b101)
                                   || (ctrl.isWord && badWordFunct);
                end
            end
            riscvPkg::OP_IMM, riscvPkg::OP_IMM_32: begin
                ctrl.isWord    = (instr.rFmt.opcode == riscvPkg::OP_IMM_32);
                // bit 30 picks sra only for shifts, elsewhere it is immediate
                ctrl.aluOp     = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
                ctrl.isCompare = !ctrl.isWord && (funct3[2:1] == 2'b01);
                ctrl.useFlag   = funct3[0] ? riscvPkg::UNSIGNED_LT : riscvPkg::SIGNED_LT;
                ctrl.illegal   = ctrl.isWord && badWordFunct;
            end
            riscvPkg::LOAD: ;               // rs1 + imm address
            riscvPkg::STORE: begin
                ctrl.writeBack = 1'b0;
                ctrl.rd        = '0;        // rd slot holds imm bits
            end
            riscvPkg::BRANCH: begin
                ctrl.srcA      = riscvPkg::PC; // value is the target
                ctrl.isBranch  = 1'b1;
                ctrl.writeBack = 1'b0;
                ctrl.rd        = '0;
                ctrl.flagInv   = funct3[0];    // bne, bge, bgeu
                case (funct3[2:1])
                    2'b00:   ctrl.useFlag = riscvPkg::EQUAL;
                    2'b10:   ctrl.useFlag = riscvPkg::SIGNED_LT;
                    2'b11:   ctrl.useFlag = riscvPkg::UNSIGNED_LT;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            riscvPkg::JAL, riscvPkg::JALR: begin
                ctrl.srcA   = riscvPkg::PC; // link value pc + 4
                ctrl.srcB   = riscvPkg::FOUR;
                ctrl.isJump = 1'b1;
            end
            riscvPkg::LUI:    ctrl.srcA = riscvPkg::ZERO;
            riscvPkg::AUIPC:  ctrl.srcA = riscvPkg::PC;
            riscvPkg::SYSTEM: ctrl.srcA = riscvPkg::ZERO; // csr address passes through
            default:          ctrl.illegal = 1'b1;
        endcase
        if (ctrl.illegal) begin
            ctrl.writeBack = 1'b0;
            ctrl.isMulDiv  = 1'b0;
        end
    end

endmodule

//--- muldiv/iterCounter.sv
`timescale 1ns/100ps
`include "core_config.svh"

module iterCounter (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic step,
    output logic last
);
    localparam int CountW = $clog2(`MULDIV_ITERS);

    logic [CountW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= CountW'(`MULDIV_ITERS - 1);
        end else if (step && !last) begin
            count <= count - 1'b1; // hold at zero
        end
    end

    assign last = (count == '0);

endmodule

//--- muldiv/mulDivCtrl.sv
`timescale 1ns/100ps

module mulDivCtrl (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last,
    output logic load,
    output logic step,
    output logic done,
    output logic busy
);
    typedef enum logic [1:0] {IDLE, RUN, FINISH} state_t;

    state_t state;
    state_t nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (start) nextState = RUN;
            RUN:     if (last) nextState = FINISH; // final bit this cycle
            FINISH:  nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    assign load = (state == IDLE) & start; // operands taken on the start cycle
    assign step = (state == RUN);
    assign done = (state == FINISH);
    assign busy = (state != IDLE);

endmodule

//--- muldiv/mulDivDatapath.sv
`timescale 1ns/100ps
`include "core_config.svh"

module mulDivDatapath (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  logic                step,
    input  riscvPkg::mulDivOp_t op,
    input  logic                isWord,
    input  logic [`XLEN-1:0]    a,
    input  logic [`XLEN-1:0]    b,
    output logic [`XLEN-1:0]    result
);
    riscvPkg::mulDivOp_t opQ;
    logic             wordQ;
    logic             negA;
    logic             negB;
    logic             divZero;
    logic             signedOp;
    logic [`XLEN-1:0] extA;
    logic [`XLEN-1:0] extB;
    logic [`XLEN-1:0] accRem;       // product accumulator or partial remainder
    logic [`XLEN-1:0] mcandDivisor;
    logic [`XLEN-1:0] mplierQuot;   // multiplier shifts out, quotient shifts in
    logic [`XLEN:0]   partial;
    logic [`XLEN:0]   diff;
    logic [`XLEN-1:0] raw;

    assign signedOp = (op != riscvPkg::DIVU) && (op != riscvPkg::REMU);

    always_comb begin
        extA = a;
        extB = b;
        if (isWord) begin
            extA = {{32{signedOp & a[31]}}, a[31:0]};
            extB = {{32{signedOp & b[31]}}, b[31:0]};
        end
    end

    assign partial = {accRem, mplierQuot[`XLEN-1]};
    assign diff    = partial - {1'b0, mcandDivisor};

    always_ff @(posedge clk) begin
        if (reset) begin
            opQ     <= riscvPkg::MUL;
            wordQ   <= 1'b0;
            negA    <= 1'b0;
            negB    <= 1'b0;
            divZero <= 1'b0;
        end else if (load) begin
            opQ     <= op;
            wordQ   <= isWord;
            negA    <= signedOp & extA[`XLEN-1];
            negB    <= signedOp & extB[`XLEN-1];
            divZero <= (extB == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            accRem       <= '0;
            mcandDivisor <= (signedOp & extB[`XLEN-1]) ? -extB : extB;
            mplierQuot   <= (signedOp & extA[`XLEN-1]) ? -extA : extA;
        end else if (step) begin
            if (opQ == riscvPkg::MUL) begin
                if (mplierQuot[0]) accRem <= accRem + mcandDivisor;
                mcandDivisor <= mcandDivisor << 1;
                mplierQuot   <= mplierQuot >> 1;
            end else if (!diff[`XLEN]) begin // divisor fits, keep the difference
                accRem     <= diff[`XLEN-1:0];
                mplierQuot <= {mplierQuot[`XLEN-2:0], 1'b1};
            end else begin
                accRem     <= partial[`XLEN-1:0];
                mplierQuot <= {mplierQuot[`XLEN-2:0], 1'b0};
            end
        end
    end

    // remainder takes the dividend sign, so x % 0 comes back as x
    always_comb begin
        case (opQ)
            riscvPkg::MUL:
                raw = (negA ^ negB) ? -accRem : accRem;
            riscvPkg::DIV, riscvPkg::DIVU:
                raw = divZero ? '1 : ((negA ^ negB) ? -mplierQuot : mplierQuot);
            default:
                raw = negA ? -accRem : accRem;
        endcase
        result = wordQ ? {{32{raw[31]}}, raw[31:0]} : raw;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 -f compile.f --top-module execStage_tb -o simv > sim.log 2>&1 \
    && ./obj_dir/simv >> sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

//--- testbench/execStage_tb.sv
`timescale 1ns/100ps
`include "core_config.svh"

module execStage_tb;
    localparam int MaxRows = 80;
    localparam logic [63:0] OpA = 64'h0123_4567_89ab_cdef;
    localparam logic [63:0] OpB = 64'hfedc_ba98_7654_3210;
    localparam logic [63:0] Pc0 = 64'h0000_0000_8000_1000;
    localparam logic [63:0] Min64 = 64'h8000_0000_0000_0000;

    logic clk = 1'b0;
    logic reset;
    logic issue;
    logic [31:0] instr;
    logic [63:0] pc;
    logic [63:0] rs1Data;
    logic [63:0] rs2Data;
    logic busy;
    logic resultValid;
    riscvPkg::execResult_t result;

    logic [31:0] tInstr [MaxRows];
    logic [63:0] tPc [MaxRows];
    logic [63:0] tRs1 [MaxRows];
    logic [63:0] tRs2 [MaxRows];
    logic [63:0] tValue [MaxRows];
    logic [4:0]  tRd [MaxRows];
    logic        tTaken [MaxRows];
    logic        tIllegal [MaxRows];
    int          nRows = 0;
    logic [31:0] lfsr = 32'hcf83_045a;
    int          cycles = 0;
    int          limit = 1000000;

    execStage i_dut (
        .clk(clk), .reset(reset), .issue(issue), .instr(instr), .pc(pc),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .busy(busy),
        .resultValid(resultValid), .result(result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("Test FAILED");
            $fatal(1, "simulation stopped");
        end
    end

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string name);
        if (got !== exp)
            stopRun($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkRd(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp)
            stopRun($sformatf("mismatch at %0t: result.rd got %0d expected %0d", $time, got, exp));
    endtask

    task automatic checkFlags(input riscvPkg::execResult_t got, input riscvPkg::execResult_t exp);
        if (got.branchTaken !== exp.branchTaken)
            stopRun($sformatf("mismatch at %0t: result.branchTaken got %b expected %b",
                              $time, got.branchTaken, exp.branchTaken));
        if (got.illegal !== exp.illegal)
            stopRun($sformatf("mismatch at %0t: result.illegal got %b expected %b",
                              $time, got.illegal, exp.illegal));
    endtask

    // taps 32, 22, 2, 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] randWord();
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < 64; i++) r = {r[62:0], lfsrBit()};
        return r;
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sType(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic isMulDivInstr(input logic [31:0] ins);
        return (ins[6:0] == 7'b0110011 || ins[6:0] == 7'b0111011) && ins[31:25] == 7'd1
            && !(ins[14:12] inside {3'b001, 3'b010, 3'b011});
    endfunction

    // M extension rules with word forms on extended operands
    function automatic logic [63:0] mulDivModel(input logic [31:0] ins, input logic [63:0] a,
            input logic [63:0] b);
        logic [2:0]  f3;
        logic        word;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] r;
        f3 = ins[14:12];
        word = ins[3];
        x = a;
        y = b;
        if (word) begin
            x = f3[0] ? {32'b0, a[31:0]} : sext32(a[31:0]);
            y = f3[0] ? {32'b0, b[31:0]} : sext32(b[31:0]);
        end
        r = x * y;
        if (f3 == 3'b100) begin
            if (y == 0) r = '1;
            else if (x == Min64 && y == '1) r = x;
            else r = $signed(x) / $signed(y);
        end else if (f3 == 3'b101) begin
            r = (y == 0) ? '1 : x / y;
        end else if (f3 == 3'b110) begin
            if (y == 0) r = x;
            else if (x == Min64 && y == '1) r = '0;
            else r = $signed(x) % $signed(y);
        end else if (f3 == 3'b111) begin
            r = (y == 0) ? x : x % y;
        end
        return word ? sext32(r[31:0]) : r;
    endfunction

    function automatic logic branchModel(input logic [2:0] f3, input logic [63:0] a,
            input logic [63:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic addRow(input logic [31:0] ins, input logic [63:0] p, input logic [63:0] a,
            input logic [63:0] b, input logic [63:0] val, input logic [4:0] rd,
            input logic taken, input logic ill);
        tInstr[nRows] = ins;
        tPc[nRows] = p;
        tRs1[nRows] = a;
        tRs2[nRows] = b;
        tValue[nRows] = val;
        tRd[nRows] = rd;
        tTaken[nRows] = taken;
        tIllegal[nRows] = ill;
        nRows++;
    endtask

    task automatic addRandomMulDiv(input logic [2:0] f3, input logic [6:0] opc);
        logic [31:0] ins;
        logic [63:0] a;
        logic [63:0] b;
        ins = rType(7'd1, 5'd2, 5'd1, f3, 5'd9, opc);
        a = randWord();
        b = randWord();
        addRow(ins, Pc0, a, b, mulDivModel(ins, a, b), 5'd9, 1'b0, 1'b0);
    endtask

    task automatic addRandomBranch(input logic [2:0] f3, input logic equalPair);
        logic [63:0] a;
        logic [63:0] b;
        a = randWord();
        b = equalPair ? a : randWord();
        addRow(bType(13'h1ff0, f3), Pc0, a, b, Pc0 - 64'd16, 5'd0, branchModel(f3, a, b), 1'b0);
    endtask

    task automatic buildTable();
        addRow(rType(7'h00, 2, 1, 3'd0, 3, riscvPkg::OP), Pc0, OpA, OpB, OpA + OpB, 3, 0, 0);
        addRow(rType(7'h20, 2, 1, 3'd0, 3, riscvPkg::OP), Pc0, OpA, OpB, OpA - OpB, 3, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd4, 4, riscvPkg::OP), Pc0, OpA, OpB, OpA ^ OpB, 4, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd6, 5, riscvPkg::OP), Pc0, OpA, OpB, OpA | OpB, 5, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd7, 6, riscvPkg::OP), Pc0, OpA, OpB, OpA & OpB, 6, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd1, 7, riscvPkg::OP), Pc0, OpA, 64'h44, OpA << 4, 7, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd5, 8, riscvPkg::OP), Pc0, OpB, 64'h44, OpB >> 4, 8, 0, 0);
        addRow(rType(7'h20, 2, 1, 3'd5, 8, riscvPkg::OP), Pc0, OpB, 64'h44,
               {4'hf, OpB[63:4]}, 8, 0, 0);
        addRow(iType(12'h800, 1, 3'd0, 10, riscvPkg::OP_IMM), Pc0, OpA, 0, OpA - 64'd2048, 10, 0, 0);
        addRow(iType(12'd12, 1, 3'd1, 10, riscvPkg::OP_IMM), Pc0, OpA, 0, OpA << 12, 10, 0, 0);
        addRow(iType(12'd8, 1, 3'd5, 10, riscvPkg::OP_IMM), Pc0, OpB, 0, OpB >> 8, 10, 0, 0);
        addRow(iType(12'h408, 1, 3'd5, 10, riscvPkg::OP_IMM), Pc0, OpB, 0,
               {8'hff, OpB[63:8]}, 10, 0, 0);
        addRow(iType(12'hfff, 1, 3'd4, 11, riscvPkg::OP_IMM), Pc0, OpA, 0, ~OpA, 11, 0, 0);
        addRow(iType(12'h7ff, 1, 3'd0, 12, riscvPkg::OP_IMM_32), Pc0, 64'h7fff_f900, 0,
               sext32(32'h7fff_f900 + 32'h7ff), 12, 0, 0);
        addRow(rType(7'h20, 2, 1, 3'd0, 13, riscvPkg::OP_32), Pc0, OpA, OpB,
               sext32(OpA[31:0] - OpB[31:0]), 13, 0, 0);
        addRow({20'hfedcb, 5'd14, 7'b0110111}, Pc0, OpA, 0, sext32(32'hfedc_b000), 14, 0, 0);
        addRow({20'h12345, 5'd14, 7'b0010111}, Pc0, OpA, 0, Pc0 + 64'h1234_5000, 14, 0, 0);
        // OpB is negative as a signed value
        addRow(rType(7'h00, 2, 1, 3'd2, 15, riscvPkg::OP), Pc0, OpA, OpB, 0, 15, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd3, 15, riscvPkg::OP), Pc0, OpA, OpB, 1, 15, 0, 0);
        addRow(rType(7'h00, 2, 1, 3'd2, 15, riscvPkg::OP), Pc0, OpB, OpA, 1, 15, 0, 0);
        addRow(iType(12'd3, 1, 3'd2, 16, riscvPkg::OP_IMM), Pc0, -64'sd5, 0, 1, 16, 0, 0);
        addRow(iType(12'd3, 1, 3'd3, 16, riscvPkg::OP_IMM), Pc0, -64'sd5, 0, 0, 16, 0, 0);
        addRow(iType(12'hfff, 1, 3'd3, 16, riscvPkg::OP_IMM), Pc0, 64'd5, 0, 1, 16, 0, 0);
        foreach (tRd[k]) begin
            if (k < 6) begin
                addRandomBranch((k < 2) ? 3'(k) : 3'(k + 2), 1'b0);
                addRandomBranch((k < 2) ? 3'(k) : 3'(k + 2), 1'b1);
            end
        end
        addRow(jType(21'h800, 5'd1), Pc0, OpA, 0, Pc0 + 64'd4, 1, 1, 0);
        addRow(iType(12'h10, 1, 3'd0, 1, riscvPkg::JALR), Pc0, OpA, 0, Pc0 + 64'd4, 1, 1, 0);
        addRow(iType(12'hff8, 1, 3'd3, 17, riscvPkg::LOAD), Pc0, OpA, 0, OpA - 64'd8, 17, 0, 0);
        addRow(sType(12'h7f0, 3'd3), Pc0, OpA, OpB, OpA + 64'h7f0, 0, 0, 0);
        addRow(iType(12'hc00, 0, 3'd2, 4, riscvPkg::SYSTEM), Pc0, OpA, 0, 64'hc00, 4, 0, 0);
        for (int k = 0; k < 8; k++) begin
            if (k != 1 && k != 2 && k != 3) begin
                addRandomMulDiv(3'(k), riscvPkg::OP);
                addRandomMulDiv(3'(k), riscvPkg::OP_32);
            end
        end
        // divide by zero and signed overflow
        addRow(rType(1, 2, 1, 3'd4, 20, riscvPkg::OP), Pc0, OpA, 0, '1, 20, 0, 0);
        addRow(rType(1, 2, 1, 3'd6, 20, riscvPkg::OP), Pc0, OpA, 0, OpA, 20, 0, 0);
        addRow(rType(1, 2, 1, 3'd5, 20, riscvPkg::OP_32), Pc0, OpA, 0, '1, 20, 0, 0);
        addRow(rType(1, 2, 1, 3'd7, 20, riscvPkg::OP_32), Pc0, OpA, 0, sext32(OpA[31:0]), 20, 0, 0);
        addRow(rType(1, 2, 1, 3'd4, 21, riscvPkg::OP), Pc0, Min64, '1, Min64, 21, 0, 0);
        addRow(rType(1, 2, 1, 3'd6, 21, riscvPkg::OP), Pc0, Min64, '1, 0, 21, 0, 0);
        addRow(rType(1, 2, 1, 3'd4, 21, riscvPkg::OP_32), Pc0, 64'h8000_0000, '1,
               64'hffff_ffff_8000_0000, 21, 0, 0);
        addRow(rType(1, 2, 1, 3'd6, 21, riscvPkg::OP_32), Pc0, 64'h8000_0000, '1, 0, 21, 0, 0);
        // illegal opcode and mulh
        addRow({20'h0, 5'd5, 7'h7f}, Pc0, OpA, OpB, 0, 5, 0, 1);
        addRow(rType(1, 2, 1, 3'd1, 6, riscvPkg::OP), Pc0, OpA, OpB, 0, 6, 0, 1);
    endtask

    task automatic runRow(input int i);
        int waitCycles;
        int expLatency;
        riscvPkg::execResult_t exp;
        @(posedge clk);
        issue   <= 1'b1;
        instr   <= tInstr[i];
        pc      <= tPc[i];
        rs1Data <= tRs1[i];
        rs2Data <= tRs2[i];
        @(posedge clk);                                  // accepted here
        instr   <= rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd31, riscvPkg::OP); // must be dropped
        rs1Data <= ~tRs1[i];
        waitCycles = 0;
        do begin
            @(posedge clk);
            issue <= 1'b0;
            waitCycles++;
            @(negedge clk);
            if (!resultValid && !busy)
                stopRun($sformatf("busy dropped before the result of row %0d", i));
        end while (!resultValid && waitCycles < `MULDIV_ITERS + 10);
        if (!resultValid)
            stopRun($sformatf("no resultValid for row %0d", i));
        expLatency = isMulDivInstr(tInstr[i]) ? `MULDIV_ITERS + 3 : 2;
        if (waitCycles != expLatency)
            stopRun($sformatf("mismatch at %0t: resultValid latency got %0d expected %0d",
                              $time, waitCycles, expLatency));
        exp = '0;
        exp.branchTaken = tTaken[i];
        exp.illegal = tIllegal[i];
        checkValue(result.value, tValue[i], "result.value");
        checkRd(result.rd, tRd[i]);
        checkFlags(result, exp);
        repeat (3) begin
            @(negedge clk);
            if (resultValid)
                stopRun($sformatf("second resultValid after row %0d", i));
        end
    endtask

    initial begin
        reset   = 1'b1;
        issue   = 1'b0;
        instr   = '0;
        pc      = '0;
        rs1Data = '0;
        rs2Data = '0;
        buildTable();
        limit = 10 + nRows * (`MULDIV_ITERS + 10);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || resultValid !== 1'b0)
            stopRun("busy or resultValid not low after reset");
        for (int i = 0; i < nRows; i++) runRow(i);
        $display("Test OK");
        $finish;
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps
`include "core_config.svh"

module alu (
    input  riscvPkg::ctrl_t  ctrl,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] value,
    output logic             branchTaken
);
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] cmpB;
    logic [`XLEN-1:0] raw;
    logic [5:0]       shamt;
    logic             flagSel;
    logic             flag;

    always_comb begin
        case (ctrl.srcA)
            riscvPkg::RS1: opA = rs1Data;
            riscvPkg::PC:  opA = pc;
            default:       opA = '0;
        endcase
        case (ctrl.srcB)
            riscvPkg::IMM:  opB = imm;
            riscvPkg::FOUR: opB = `XLEN'(4);
            default:        opB = rs2Data;
        endcase
    end

    assign shamt = ctrl.isWord ? {1'b0, opB[4:0]} : opB[5:0]; // W shifts use 5 bits

    always_comb begin
        case (ctrl.aluOp)
            riscvPkg::ADD: raw = opA + opB;
            riscvPkg::SUB: raw = opA - opB;
            riscvPkg::XOR: raw = opA ^ opB;
            riscvPkg::OR:  raw = opA | opB;
            riscvPkg::AND: raw = opA & opB;
            riscvPkg::SLL: raw = opA << shamt;
            riscvPkg::SRL: raw = (ctrl.isWord ? {32'b0, opA[31:0]} : opA) >> shamt;
            default:       raw = $signed(ctrl.isWord ? {{32{opA[31]}}, opA[31:0]} : opA) >>> shamt;
        endcase
    end

    // branches compare registers, slt forms compare rs1 with operand b
    assign cmpB = ctrl.isBranch ? rs2Data : opB;

    always_comb begin
        case (ctrl.useFlag)
            riscvPkg::UNSIGNED_LT: flagSel = rs1Data < cmpB;
            riscvPkg::EQUAL:       flagSel = rs1Data == cmpB;
            default:               flagSel = $signed(rs1Data) < $signed(cmpB);
        endcase
    end

    assign flag = flagSel ^ ctrl.flagInv;

    always_comb begin
        if (ctrl.isCompare) value = `XLEN'(flag);
        else if (ctrl.isWord) value = {{32{raw[31]}}, raw[31:0]};
        else value = raw;
    end

    assign branchTaken = ctrl.isJump | (ctrl.isBranch & flag);

endmodule

//--- verilog/execStage.sv
`timescale 1ns/100ps
`include "core_config.svh"

module execStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue,
    input  logic [`ILEN-1:0]      instr,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      rs1Data,
    input  logic [`XLEN-1:0]      rs2Data,
    output logic                  busy,
    output logic                  resultValid,
    output riscvPkg::execResult_t result
);
    riscvPkg::instrWord_t instrQ;
    riscvPkg::ctrl_t      ctrl;
    logic [`XLEN-1:0] pcQ;
    logic [`XLEN-1:0] rs1Q;
    logic [`XLEN-1:0] rs2Q;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] aluValue;
    logic [`XLEN-1:0] aluQ;
    logic [`XLEN-1:0] mdResult;
    logic             branchTaken;
    logic             takenQ;
    logic             accept;
    logic             inFlight;
    logic             decodeQ;     // first cycle after capture
    logic             execQ;       // second cycle, non-M result written here
    logic             start;
    logic             load;
    logic             step;
    logic             last;
    logic             done;
    logic             mdBusy;

    assign busy   = inFlight | mdBusy;
    assign accept = issue & ~busy; // issue while busy is dropped
    assign start  = execQ & ctrl.isMulDiv;

    always_ff @(posedge clk) begin
        if (accept) begin
            instrQ <= riscvPkg::instrWord_t'(instr);
            pcQ    <= pc;
            rs1Q   <= rs1Data;
            rs2Q   <= rs2Data;
        end
        if (decodeQ) begin
            aluQ   <= aluValue;
            takenQ <= branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inFlight    <= 1'b0;
            decodeQ     <= 1'b0;
            execQ       <= 1'b0;
            resultValid <= 1'b0;
            result      <= '0;
        end else begin
            decodeQ     <= accept;
            execQ       <= decodeQ;
            resultValid <= 1'b0;
            if (accept) inFlight <= 1'b1;
            if (execQ && !ctrl.isMulDiv) begin
                result.value       <= ctrl.illegal ? '0 : aluQ;
                result.rd          <= ctrl.rd;
                result.branchTaken <= takenQ;
                result.illegal     <= ctrl.illegal;
                resultValid        <= 1'b1;
                inFlight           <= 1'b0;
            end else if (done) begin
                result.value       <= mdResult;
                result.rd          <= ctrl.rd;
                result.branchTaken <= 1'b0;
                result.illegal     <= 1'b0;
                resultValid        <= 1'b1;
                inFlight           <= 1'b0;
            end
        end
    end

    mainDecoder uDecoder (.instr(instrQ), .ctrl(ctrl));

    immGen uImmGen (.instr(instrQ), .imm(imm));

    alu uAlu (
        .ctrl(ctrl), .rs1Data(rs1Q), .rs2Data(rs2Q), .pc(pcQ), .imm(imm),
        .value(aluValue), .branchTaken(branchTaken)
    );

    mulDivCtrl uMulDivCtrl (
        .clk(clk), .reset(reset), .start(start), .last(last),
        .load(load), .step(step), .done(done), .busy(mdBusy)
    );

    iterCounter uIterCounter (.clk(clk), .reset(reset), .load(load), .step(step), .last(last));

    mulDivDatapath uMulDivDatapath (
        .clk(clk), .reset(reset), .load(load), .step(step), .op(ctrl.mulDivOp),
        .isWord(ctrl.isWord), .a(rs1Q), .b(rs2Q), .result(mdResult)
    );

endmodule
